//--- run.sh
#!/bin/sh
# build and run the capture engine testbench, the log decides the result
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --top-module scope_tb -f src.f -o scope_sim \
  && ./obj_dir/scope_sim > sim.log 2>&1 \
  || echo "Simulation failed (build or run error)" >> sim.log
cat sim.log
if grep -q "Simulation failed" sim.log; then exit 1; fi
exit 0

//--- src.f
src/scope_pkg.sv
src/scope_decimator.sv
src/scope_trigger.sv
src/scope_capture_buf.sv
src/scope_regs.sv
src/scope_top.sv
verif/scope_tb.sv

//--- src/scope_capture_buf.sv
//--------------------------------------------------------------------------
// scope capture buffer
// circular sample ram with write pointer, trigger pointer and a one cycle
// read port for the bus
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module scope_capture_buf
  import scope_pkg::*;
#(
  parameter int dwi_p = scope_pkg::dwi_p,
  parameter int rsz_p = scope_pkg::rsz_p
) (
  input  wire                     clk,
  input  wire                     rstn,
  input  wire                     we_i,       // writing enabled
  input  wire                     dec_vld_i,  // sample strobe
  input  wire signed [dwi_p-1:0]  dec_dat_i,
  input  wire                     trg_i,      // latch trigger pointer
  input  wire                     clr_i,      // zero both pointers
  input  wire                     rd_en_i,
  input  wire        [rsz_p-1:0]  rd_addr_i,
  output logic signed [dwi_p-1:0] rd_dat_o,
  output logic       [rsz_p-1:0]  wp_cur_o,
  output logic       [rsz_p-1:0]  wp_trig_o
);

  logic signed [dwi_p-1:0] mem [0:2**rsz_p-1];
  logic                    wr;

  assign wr = we_i && dec_vld_i && !clr_i;

  //--------------------------------------------------------------------------
  // sample ram

  always_ff @(posedge clk) begin
    if (wr) begin
      mem[wp_cur_o] <= dec_dat_i;
    end
    if (rd_en_i) begin
      rd_dat_o <= mem[rd_addr_i];  // data next cycle
    end
  end

  //--------------------------------------------------------------------------
  // pointers

  always_ff @(posedge clk) begin
    if (!rstn) begin
      wp_cur_o  <= '0;
      wp_trig_o <= '0;
    end else if (clr_i) begin
      wp_cur_o  <= '0;
      wp_trig_o <= '0;
    end else begin
      if (wr) begin
        wp_cur_o <= wp_cur_o + rsz_p'(1);  // wraps at buffer end
      end
      if (trg_i) begin
        wp_trig_o <= wp_cur_o;  // first post-trigger entry
      end
    end
  end

  // the trigger controller ends writing right after a reset command
  clr_stop_a: assert property (@(posedge clk) disable iff (!rstn)
    clr_i |=> !we_i)
    else $error("buffer still writing after reset command");

endmodule

`default_nettype wire

//--- src/scope_decimator.sv
//--------------------------------------------------------------------------
// scope decimator
// sums valid adc samples over a window of 2^dec and emits one sample per
// window, the averaged sum or the last sample taken
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module scope_decimator
  import scope_pkg::*;
#(
  parameter int dwi_p = scope_pkg::dwi_p
) (
  input  wire                     clk,
  input  wire                     rstn,
  input  wire signed [dwi_p-1:0]  sti_dat_i,  // adc sample
  input  wire                     sti_vld_i,  // sample strobe
  input  wire                     arm_i,      // restart window
  input  wire        [4:0]        dec_i,      // shift code 0..16
  input  wire                     avg_en_i,
  output logic signed [dwi_p-1:0] dec_dat_o,
  output logic                    dec_vld_o
);

  localparam int sum_w_c = dwi_p + 16;  // room for 2^16 samples

  logic        [16:0]        cnt_q;    // samples taken in window
  logic signed [sum_w_c-1:0] sum_q;    // running sum
  logic        [16:0]        win_len;  // samples per window
  logic                      last;     // window closes this cycle
  logic signed [sum_w_c-1:0] sum_nxt;

  assign win_len = 17'd1 << dec_i;
  assign last    = sti_vld_i && (cnt_q >= win_len - 17'd1);
  assign sum_nxt = sum_q + sum_w_c'(sti_dat_i);  // sign extended

  //--------------------------------------------------------------------------
  // window count and running sum

  always_ff @(posedge clk) begin
    if (!rstn) begin
      cnt_q     <= '0;
      sum_q     <= '0;
      dec_vld_o <= 1'b0;
    end else begin
      dec_vld_o <= last && !arm_i;  // arm drops a partial window
      if (arm_i || last) begin
        cnt_q <= '0;
        sum_q <= '0;
      end else if (sti_vld_i) begin
        cnt_q <= cnt_q + 17'd1;
        sum_q <= sum_nxt;
      end
    end
  end

  // output sample, held between strobes
  always_ff @(posedge clk) begin
    if (last) begin
      if (avg_en_i) begin
        dec_dat_o <= dwi_p'(sum_nxt >>> dec_i);  // mean of the window
      end else begin
        dec_dat_o <= sti_dat_i;  // plain decimation
      end
    end
  end

  // shift code comes from the register bank
  dec_range_a: assert property (@(posedge clk) disable iff (!rstn) dec_i <= 5'd16)
    else $error("decimation shift code above 16");

endmodule

`default_nettype wire

//--- src/scope_pkg.sv
//--------------------------------------------------------------------------
// scope package
// widths, register map, trigger source codes and reset values shared by
// the one-channel capture engine
//--------------------------------------------------------------------------
`default_nettype none

package scope_pkg;

  //--------------------------------------------------------------------------
  // widths

  localparam int dwi_p    = 14;  // adc sample width
  localparam int rsz_p    = 10;  // log2 of buffer entries
  localparam int dly_w_p  = 32;  // post-trigger delay counter
  localparam int bus_aw_p = 20;  // decoded bus address
  localparam int bus_dw_p = 32;  // bus data

  localparam int buf_region_bit_p = 16;  // address bit selecting buffer readback

  // reset values
  localparam logic [4:0] rst_dec_p = 5'd0;  // no decimation
  localparam logic       rst_avg_p = 1'b1;  // averaging on

  //--------------------------------------------------------------------------
  // encodings

  // trigger source codes of the register map
  typedef enum logic [3:0] {
    trg_none    = 4'd0,  // idle
    trg_sw      = 4'd1,  // software
    trg_ext_pos = 4'd6,  // external rising edge
    trg_ext_neg = 4'd7   // external falling edge
  } trg_src_e;

  typedef enum logic [bus_aw_p-1:0] {
    reg_ctrl    = 20'h00000,  // arm in b0 and reset in b1
    reg_trg_src = 20'h00004,  // trigger source
    reg_dly     = 20'h00010,  // samples kept after trigger
    reg_dec     = 20'h00014,  // decimation shift code
    reg_wp_cur  = 20'h00018,  // current write pointer
    reg_wp_trig = 20'h0001C,  // write pointer at trigger
    reg_avg_en  = 20'h00028   // averaging enable
  } reg_addr_e;

endpackage

`default_nettype wire

//--- src/scope_regs.sv
//--------------------------------------------------------------------------
// scope register bank
// system bus decode, capture settings, command pulses, status readback
// and the two cycle buffer read
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module scope_regs
  import scope_pkg::*;
#(
  parameter int dwi_p = scope_pkg::dwi_p,
  parameter int rsz_p = scope_pkg::rsz_p
) (
  input  wire                      clk,
  input  wire                      rstn,
  input  wire        [bus_aw_p-1:0] sys_addr_i,
  input  wire        [bus_dw_p-1:0] sys_wdata_i,
  input  wire                      sys_wen_i,
  input  wire                      sys_ren_i,
  output logic       [bus_dw_p-1:0] sys_rdata_o,
  output logic                     sys_ack_o,
  output logic                     sys_err_o,
  input  wire                      we_i,
  input  wire                      dly_act_i,
  input  trg_src_e                 trg_src_i,
  input  wire        [rsz_p-1:0]   wp_cur_i,
  input  wire        [rsz_p-1:0]   wp_trig_i,
  input  wire signed [dwi_p-1:0]   rd_dat_i,
  output logic                     rd_en_o,
  output logic       [rsz_p-1:0]   rd_addr_o,
  output logic                     arm_o,
  output logic                     clr_o,
  output logic                     trg_sw_o,
  output logic                     trg_src_wr_o,
  output logic       [3:0]         trg_src_val_o,
  output logic       [dly_w_p-1:0] dly_o,
  output logic       [4:0]         dec_o,
  output logic                     avg_en_o
);

  reg_addr_e           addr;
  logic                buf_sel;    // buffer region access
  logic                reg_wr;
  logic                sys_en;
  logic                rd_pend_q;  // buffer read in flight
  logic                hit;        // mapped register
  logic [bus_dw_p-1:0] rdata_d;

  assign addr      = reg_addr_e'(sys_addr_i);
  assign buf_sel   = sys_addr_i[buf_region_bit_p];
  assign sys_en    = sys_wen_i || sys_ren_i;
  assign reg_wr    = sys_wen_i && !buf_sel;
  assign rd_en_o   = sys_ren_i && buf_sel && !rd_pend_q;
  assign rd_addr_o = sys_addr_i[rsz_p+1:2];  // word index

  //--------------------------------------------------------------------------
  // settings and command pulses

  always_ff @(posedge clk) begin
    if (!rstn) begin
      dly_o        <= '0;
      dec_o        <= rst_dec_p;
      avg_en_o     <= rst_avg_p;
      arm_o        <= 1'b0;
      clr_o        <= 1'b0;
      trg_sw_o     <= 1'b0;
      trg_src_wr_o <= 1'b0;
    end else begin
      arm_o        <= reg_wr && (addr == reg_ctrl) && sys_wdata_i[0];
      clr_o        <= reg_wr && (addr == reg_ctrl) && sys_wdata_i[1];
      trg_src_wr_o <= reg_wr && (addr == reg_trg_src);
      trg_sw_o     <= reg_wr && (addr == reg_trg_src) && (sys_wdata_i[3:0] == trg_sw);
      if (reg_wr && addr == reg_dly)    dly_o    <= sys_wdata_i[dly_w_p-1:0];
      if (reg_wr && addr == reg_dec)    dec_o    <= sys_wdata_i[4:0];
      if (reg_wr && addr == reg_avg_en) avg_en_o <= sys_wdata_i[0];
    end
  end

  // source value goes out with its write strobe
  always_ff @(posedge clk) begin
    trg_src_val_o <= sys_wdata_i[3:0];
  end

  //--------------------------------------------------------------------------
  // readback

  always_comb begin
    hit     = 1'b1;
    rdata_d = '0;
    case (addr)
      reg_ctrl:    rdata_d = bus_dw_p'({dly_act_i, 1'b0, we_i});
      reg_trg_src: rdata_d = bus_dw_p'(trg_src_i);
      reg_dly:     rdata_d = bus_dw_p'(dly_o);
      reg_dec:     rdata_d = bus_dw_p'(dec_o);
      reg_wp_cur:  rdata_d = bus_dw_p'(wp_cur_i);
      reg_wp_trig: rdata_d = bus_dw_p'(wp_trig_i);
      reg_avg_en:  rdata_d = bus_dw_p'(avg_en_o);
      default:     hit     = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      rd_pend_q <= 1'b0;
      sys_ack_o <= 1'b0;
      sys_err_o <= 1'b0;
    end else begin
      rd_pend_q <= rd_en_o;
      // registers ack next cycle, buffer reads once ram data is back
      sys_ack_o <= (sys_en && !(sys_ren_i && buf_sel)) || rd_pend_q;
      sys_err_o <= sys_en && !buf_sel && !hit;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_pend_q) begin
      sys_rdata_o <= bus_dw_p'(rd_dat_i);  // sign extended sample
    end else begin
      sys_rdata_o <= rdata_d;
    end
  end

  ack_src_a: assert property (@(posedge clk) disable iff (!rstn)
    $rose(sys_ack_o) |-> $past(sys_en) || $past(sys_ren_i, 2))
    else $error("bus ack without a strobe");

endmodule

`default_nettype wire

//--- src/scope_top.sv
//--------------------------------------------------------------------------
// scope capture engine top
// decimator feeding the circular buffer, trigger controller beside it and
// the register bank on the system bus
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module scope_top
  import scope_pkg::*;
#(
  parameter int dwi_p = scope_pkg::dwi_p,
  parameter int rsz_p = scope_pkg::rsz_p
) (
  input  wire                      clk,
  input  wire                      rstn,
  input  wire signed [dwi_p-1:0]   sti_dat_i,
  input  wire                      sti_vld_i,
  input  wire                      trg_ext_i,
  output logic                     trg_o,
  input  wire        [bus_aw_p-1:0] sys_addr_i,
  input  wire        [bus_dw_p-1:0] sys_wdata_i,
  input  wire                      sys_wen_i,
  input  wire                      sys_ren_i,
  output logic       [bus_dw_p-1:0] sys_rdata_o,
  output logic                     sys_ack_o,
  output logic                     sys_err_o
);

  // register bank commands and settings
  logic                    arm;
  logic                    clr;
  logic                    trg_sw;
  logic                    trg_src_wr;
  logic [3:0]              trg_src_val;
  logic [dly_w_p-1:0]      dly;
  logic [4:0]              dec;
  logic                    avg_en;
  // sample path and status
  logic                    dec_vld;
  logic signed [dwi_p-1:0] dec_dat;
  trg_src_e                trg_src;
  logic                    we;
  logic                    dly_act;
  logic [rsz_p-1:0]        wp_cur;
  logic [rsz_p-1:0]        wp_trig;
  logic                    rd_en;
  logic [rsz_p-1:0]        rd_addr;
  logic signed [dwi_p-1:0] rd_dat;

  scope_decimator #(.dwi_p(dwi_p)) u_dec (
    .clk       (clk),
    .rstn      (rstn),
    .sti_dat_i (sti_dat_i),
    .sti_vld_i (sti_vld_i),
    .arm_i     (arm),
    .dec_i     (dec),
    .avg_en_i  (avg_en),
    .dec_dat_o (dec_dat),
    .dec_vld_o (dec_vld)
  );

  scope_trigger u_trg (
    .clk           (clk),
    .rstn          (rstn),
    .trg_ext_i     (trg_ext_i),
    .trg_sw_i      (trg_sw),
    .trg_src_wr_i  (trg_src_wr),
    .trg_src_val_i (trg_src_val),
    .arm_i         (arm),
    .clr_i         (clr),
    .dec_vld_i     (dec_vld),
    .dly_i         (dly),
    .trg_src_o     (trg_src),
    .we_o          (we),
    .dly_act_o     (dly_act),
    .trg_o         (trg_o)
  );

  scope_capture_buf #(.dwi_p(dwi_p), .rsz_p(rsz_p)) u_buf (
    .clk       (clk),
    .rstn      (rstn),
    .we_i      (we),
    .dec_vld_i (dec_vld),
    .dec_dat_i (dec_dat),
    .trg_i     (trg_o),
    .clr_i     (clr),
    .rd_en_i   (rd_en),
    .rd_addr_i (rd_addr),
    .rd_dat_o  (rd_dat),
    .wp_cur_o  (wp_cur),
    .wp_trig_o (wp_trig)
  );

  scope_regs #(.dwi_p(dwi_p), .rsz_p(rsz_p)) u_regs (
    .clk           (clk),
    .rstn          (rstn),
    .sys_addr_i    (sys_addr_i),
    .sys_wdata_i   (sys_wdata_i),
    .sys_wen_i     (sys_wen_i),
    .sys_ren_i     (sys_ren_i),
    .sys_rdata_o   (sys_rdata_o),
    .sys_ack_o     (sys_ack_o),
    .sys_err_o     (sys_err_o),
    .we_i          (we),
    .dly_act_i     (dly_act),
    .trg_src_i     (trg_src),
    .wp_cur_i      (wp_cur),
    .wp_trig_i     (wp_trig),
    .rd_dat_i      (rd_dat),
    .rd_en_o       (rd_en),
    .rd_addr_o     (rd_addr),
    .arm_o         (arm),
    .clr_o         (clr),
    .trg_sw_o      (trg_sw),
    .trg_src_wr_o  (trg_src_wr),
    .trg_src_val_o (trg_src_val),
    .dly_o         (dly),
    .dec_o         (dec),
    .avg_en_o      (avg_en)
  );

endmodule

`default_nettype wire

//--- src/scope_trigger.sv
//--------------------------------------------------------------------------
// scope trigger controller
// synchronizes the external trigger, selects the trigger event and runs
// the arm, trigger and post-trigger delay sequence
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module scope_trigger
  import scope_pkg::*;
(
  input  wire                clk,
  input  wire                rstn,
  input  wire                trg_ext_i,      // async external trigger
  input  wire                trg_sw_i,       // software trigger pulse
  input  wire                trg_src_wr_i,   // source register write
  input  wire  [3:0]         trg_src_val_i,
  input  wire                arm_i,
  input  wire                clr_i,
  input  wire                dec_vld_i,      // decimated sample strobe
  input  wire  [dly_w_p-1:0] dly_i,          // samples kept after trigger
  output trg_src_e           trg_src_o,
  output logic               we_o,           // buffer writing enabled
  output logic               dly_act_o,      // post-trigger delay running
  output logic               trg_o           // accepted trigger pulse
);

  logic [2:0]         ext_q;    // two sync stages plus edge history
  logic               ext_pos;
  logic               ext_neg;
  trg_src_e           src_q;
  trg_src_e           src_sel;  // source seen by this cycle's event
  logic               evt;
  logic               accept;
  logic               done;     // last post-trigger sample is in
  logic               we_q;
  logic [dly_w_p-1:0] cnt_q;    // samples still to write

  assign ext_pos = ext_q[1] && !ext_q[2];
  assign ext_neg = !ext_q[1] && ext_q[2];
  assign src_sel = trg_src_wr_i ? trg_src_e'(trg_src_val_i) : src_q;

  always_comb begin
    case (src_sel)
      trg_sw:      evt = trg_sw_i;
      trg_ext_pos: evt = ext_pos;
      trg_ext_neg: evt = ext_neg;
      default:     evt = 1'b0;  // trg_none and unused codes
    endcase
  end

  assign done      = dly_act_o && (cnt_q == '0);
  assign we_o      = we_q && !done;  // stop in the same cycle
  assign accept    = evt && we_o && !dly_act_o;
  assign trg_src_o = src_q;

  //--------------------------------------------------------------------------
  // arm, trigger and delay state

  always_ff @(posedge clk) begin
    if (!rstn) begin
      ext_q     <= '0;
      we_q      <= 1'b0;
      dly_act_o <= 1'b0;
      trg_o     <= 1'b0;
      src_q     <= trg_none;
      cnt_q     <= '0;
    end else begin
      ext_q <= {ext_q[1:0], trg_ext_i};
      trg_o <= accept && !clr_i && !arm_i;
      if (clr_i || done) begin
        we_q      <= 1'b0;
        dly_act_o <= 1'b0;
      end else if (arm_i) begin
        we_q      <= 1'b1;  // accepted in any state
        dly_act_o <= 1'b0;
      end else if (accept) begin
        dly_act_o <= 1'b1;
      end
      if (trg_src_wr_i) begin
        src_q <= trg_src_e'(trg_src_val_i);
      end else if (done || clr_i) begin
        src_q <= trg_none;  // one-shot source
      end
      if (!dly_act_o) begin
        cnt_q <= dly_i;
      end else if (dec_vld_i && cnt_q != '0) begin
        cnt_q <= cnt_q - dly_w_p'(1);
      end
    end
  end

  // trigger only from a live capture, and it starts the delay
  trg_we_a: assert property (@(posedge clk) disable iff (!rstn)
    trg_o |-> $past(we_o) && dly_act_o)
    else $error("trigger pulse outside an armed capture");

endmodule

`default_nettype wire

//--- verif/scope_golden.txt
# op addr data, addr and data in hex; rd compares data, wt and cb take a count in data
# wr write, rd read, er unmapped read, wt decimated samples, ep/en ext edge, cb/cp model checks
rd 00000 00000000
rd 00014 00000000
rd 00028 00000001
wr 00010 00000010
rd 00010 00000010
er 00008 00000000
wr 00000 00000001
wt 00000 00000014
wr 00004 00000001
wt 00000 0000001e
rd 00000 00000000
rd 00004 00000000
rd 00018 00000024
rd 0001c 00000014
cp 00000 00000000
wr 00014 00000003
rd 00014 00000003
wr 00000 00000001
wt 00000 0000000c
cb 00000 0000000c
wr 00028 00000000
wr 00000 00000001
wt 00000 0000000c
cb 00000 0000000c
wr 00014 00000000
wr 00004 00000006
rd 00004 00000006
wr 00000 00000001
wt 00000 0000000a
ep 00000 00000000
wt 00000 00000014
rd 0001c 00000046
cp 00000 00000000
en 00000 00000000
wr 00004 00000007
rd 00004 00000007
wr 00000 00000001
wt 00000 0000000a
ep 00000 00000000
en 00000 00000000
wt 00000 00000014
rd 0001c 00000060
cp 00000 00000000
wr 00000 00000001
wr 00004 00000001
wt 00000 00000005
rd 00000 00000005
wr 00000 00000002
rd 00018 00000000
rd 0001c 00000000
rd 00000 00000000
cp 00000 00000000

//--- verif/scope_tb.sv
//--------------------------------------------------------------------------
// scope capture engine testbench
// runs the golden command script against the DUT, with a model of the
// decimated stream, the circular buffer and the trigger sequence
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module scope_tb;

  logic        clk;
  logic        rstn;
  logic [13:0] sti_dat_i;
  logic        sti_vld_i;
  logic        trg_ext_i;
  logic        trg_o;
  logic [19:0] sys_addr_i;
  logic [31:0] sys_wdata_i;
  logic        sys_wen_i;
  logic        sys_ren_i;
  logic [31:0] sys_rdata_o;
  logic        sys_ack_o;
  logic        sys_err_o;

  logic [31:0]        seed;             // lcg state
  logic signed [13:0] m_mem [0:1023];   // model buffer
  int                 m_wp;             // model write pointer
  int                 m_tp;             // model trigger pointer
  int                 m_cnt;            // samples in window
  int                 m_sum;
  int                 m_left;           // post-trigger samples to go
  int                 m_ndec;           // decimated samples so far
  int                 m_ntrg;           // expected trigger pulses
  logic [4:0]         m_dec;
  logic               m_avg;
  logic               m_wr;             // capture writing
  logic               m_act;            // delay running
  logic [3:0]         m_src;
  logic [31:0]        m_dly;
  int                 trg_seen = 0;     // trg_o pulses seen
  int                 checks = 0;
  int                 mismatches = 0;
  int                 fails = 0;

  scope_top #(.dwi_p(14), .rsz_p(10)) DUT (
    .clk         (clk),
    .rstn        (rstn),
    .sti_dat_i   (sti_dat_i),
    .sti_vld_i   (sti_vld_i),
    .trg_ext_i   (trg_ext_i),
    .trg_o       (trg_o),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 125 MHz
  end

  always @(negedge clk) begin
    if (rstn && trg_o) trg_seen <= trg_seen + 1;  // stable half a cycle after edge
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH at %0t ns: %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      sti_vld_i = 1'b0;
      @(posedge clk);
      #1;
    end
  endtask

  //--------------------------------------------------------------------------
  // reference model

  task automatic end_capture();
    m_wr  = 1'b0;
    m_act = 1'b0;
    m_src = 4'd0;  // one-shot source back to none
  endtask

  task automatic fire_trigger();
    if (m_wr && !m_act) begin
      m_act  = 1'b1;
      m_tp   = m_wp;  // first post-trigger entry
      m_left = int'(m_dly);
      m_ntrg++;
      if (m_left == 0) end_capture();
    end
  endtask

  task automatic accumulate_sample(input logic signed [13:0] s);
    logic signed [13:0] out;
    m_sum = m_sum + int'(s);
    m_cnt++;
    if (m_cnt == (1 << m_dec)) begin  // window complete
      out    = m_avg ? 14'(m_sum >>> m_dec) : s;
      m_cnt  = 0;
      m_sum  = 0;
      m_ndec++;
      if (m_wr) begin
        m_mem[m_wp] = out;
        m_wp = (m_wp + 1) % 1024;  // circular
        if (m_act) begin
          m_left--;
          if (m_left == 0) end_capture();
        end
      end
    end
  endtask

  task automatic shadow_write(input logic [19:0] addr, input logic [31:0] data);
    case (addr)
      20'h00000: begin
        if (data[0]) begin
          m_cnt = 0;  // arm restarts the window
          m_sum = 0;
        end
        if (data[1]) begin
          m_wr  = 1'b0;
          m_act = 1'b0;
          m_wp  = 0;
          m_tp  = 0;
          m_src = 4'd0;
        end else if (data[0]) begin
          m_wr  = 1'b1;
          m_act = 1'b0;
        end
      end
      20'h00004: begin
        m_src = data[3:0];
        if (data[3:0] == 4'd1) fire_trigger();  // software trigger
      end
      20'h00010: m_dly = data;
      20'h00014: m_dec = data[4:0];
      20'h00028: m_avg = data[0];
      default: ;
    endcase
  endtask

  //--------------------------------------------------------------------------
  // stimulus and bus

  task automatic stream_cycle();
    seed      = lcg_next(seed);
    sti_dat_i = seed[13:0];
    sti_vld_i = seed[31];
    if (seed[31]) accumulate_sample(seed[13:0]);
    @(posedge clk);
    #1;
  endtask

  task automatic wait_dec(input int n);
    int target;
    int guard;
    target = m_ndec + n;
    guard  = 0;
    while (m_ndec < target && guard < 5000) begin
      stream_cycle();
      guard++;
    end
    sti_vld_i = 1'b0;
    if (m_ndec < target) begin
      fails++;
      $display("ERROR at %0t ns: timeout streaming %0d decimated samples", $time, n);
    end
    idle(4);  // last sample reaches the buffer
  endtask

  task automatic bus_access(input logic wen, input logic [19:0] addr, input logic [31:0] wdata,
                            input logic exp_err, output logic [31:0] rdata);
    int guard;
    sys_addr_i  = addr;
    sys_wdata_i = wdata;
    sys_wen_i   = wen;
    sys_ren_i   = !wen;
    @(posedge clk);
    #1;
    sys_wen_i = 1'b0;
    sys_ren_i = 1'b0;
    guard     = 0;
    while (!sys_ack_o && guard < 8) begin
      @(posedge clk);
      #1;
      guard++;
    end
    rdata = sys_rdata_o;
    if (!sys_ack_o) begin
      fails++;
      $display("ERROR at %0t ns: no bus acknowledge for address %h", $time, addr);
    end
    check_val($sformatf("sys_err_o @%h", addr), {31'd0, exp_err}, {31'd0, sys_err_o});
    @(posedge clk);
    #1;
  endtask

  task automatic ext_edge(input logic level);
    int guard;
    trg_ext_i = level;
    if (m_src == (level ? 4'd6 : 4'd7)) fire_trigger();
    guard = 0;
    while (trg_seen != m_ntrg && guard < 20) begin
      @(posedge clk);
      #1;
      guard++;
    end
    if (trg_seen != m_ntrg) begin
      fails++;
      $display("ERROR at %0t ns: timeout waiting for trigger on external edge", $time);
    end
    idle(8);  // synchronizer settles, catches a stray pulse
    check_val("trg_o pulses", 32'(m_ntrg), 32'(trg_seen));
  endtask

  task automatic compare_buf(input int n);
    int          i;
    int          idx;
    logic [31:0] rd;
    for (i = 0; i < n; i++) begin
      idx = (m_wp - n + i + 1024) % 1024;  // last n entries written
      bus_access(1'b0, 20'h10000 | 20'(idx << 2), 32'd0, 1'b0, rd);
      check_val($sformatf("buffer[%0d]", idx), 32'(m_mem[idx]), rd);
    end
  endtask

  task automatic compare_ptrs();
    logic [31:0] rd;
    bus_access(1'b0, 20'h00018, 32'd0, 1'b0, rd);
    check_val("reg_wp_cur", 32'(m_wp), rd);
    bus_access(1'b0, 20'h0001c, 32'd0, 1'b0, rd);
    check_val("reg_wp_trig", 32'(m_tp), rd);
    check_val("trg_o pulses", 32'(m_ntrg), 32'(trg_seen));
  endtask

  task automatic run_cmd(input logic [15:0] op, input logic [19:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    case (op)
      "wr": begin
        bus_access(1'b1, addr, data, 1'b0, rd);
        shadow_write(addr, data);
      end
      "rd": begin
        bus_access(1'b0, addr, 32'd0, 1'b0, rd);
        check_val($sformatf("sys_rdata_o @%h", addr), data, rd);
      end
      "er": bus_access(1'b0, addr, 32'd0, 1'b1, rd);
      "wt": wait_dec(int'(data));
      "ep": ext_edge(1'b1);
      "en": ext_edge(1'b0);
      "cb": compare_buf(int'(data));
      "cp": compare_ptrs();
      default: begin
        fails++;
        $display("ERROR: unknown command %s in golden file", op);
      end
    endcase
  endtask

  //--------------------------------------------------------------------------
  // main sequence

  initial begin
    int          fd;
    int          nf;
    string       text;
    logic [15:0] op;
    logic [19:0] addr;
    logic [31:0] data;
    rstn        = 1'b0;
    sti_dat_i   = '0;
    sti_vld_i   = 1'b0;
    trg_ext_i   = 1'b0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    seed        = 32'hc78b80c7;
    m_wp        = 0;
    m_tp        = 0;
    m_cnt       = 0;
    m_sum       = 0;
    m_left      = 0;
    m_ndec      = 0;
    m_ntrg      = 0;
    m_dec       = 5'd0;  // reset shift code
    m_avg       = 1'b1;  // averaging on after reset
    m_wr        = 1'b0;
    m_act       = 1'b0;
    m_src       = 4'd0;
    m_dly       = 32'd0;
    repeat (16) @(posedge clk);
    #1;
    rstn = 1'b1;
    idle(2);
    fd = $fopen("verif/scope_golden.txt", "r");
    if (fd == 0) begin
      fails++;
      $display("ERROR: cannot open verif/scope_golden.txt");
    end else begin
      while (!$feof(fd)) begin
        text = "";
        nf   = $fgets(text, fd);
        if (text.len() > 1 && text.getc(0) != "#") begin  // skip comments and blanks
          nf = $sscanf(text, "%s %h %h", op, addr, data);
          if (nf == 3) begin
            run_cmd(op, addr, data);
          end else begin
            fails++;
            $display("ERROR: malformed golden line %s", text);
          end
        end
      end
      $fclose(fd);
    end
    $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, fails);
    if (mismatches == 0 && fails == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
